//--- mmio_pkg.sv
package mmio_pkg;

    parameter int xlen = 32;

    // peripherals sit at the top of the address space, everything else is memory.
    parameter logic [xlen-1:0] uart_tx_addr = 32'hff00_0000;
    parameter logic [xlen-1:0] uart_rx_addr = 32'hff00_0010;
    parameter logic [xlen-1:0] clint_base   = 32'hff00_0100;
    parameter logic [xlen-1:0] clint_end    = 32'hff00_010f;

    typedef enum logic [1:0] {
        errty_none         = 2'd0,
        errty_access_fault = 2'd1
    } mmio_errty_e;

endpackage

//--- mmio_uart_tx.sv
module mmio_uart_tx #(
    parameter int CLKS_PER_BIT = 234
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_wen,
    input  logic [mmio_pkg::xlen-1:0] req_wdata,
    output logic                      resp_valid,
    output logic [mmio_pkg::xlen-1:0] resp_rdata,
    output logic                      uart_tx
);
    import mmio_pkg::*;

    localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);

    logic             busy;
    logic [9:0]       frame;
    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic             accept;
    logic             bit_end;

    assign req_ready = !busy;
    assign accept    = req_valid && req_ready;
    assign bit_end   = busy && baud_cnt == cnt_w'(CLKS_PER_BIT - 1);

    // the line idles high between frames.
    assign uart_tx = busy ? frame[0] : 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
            if (accept && req_wen) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end else if (bit_end) begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (busy) begin
                baud_cnt <= baud_cnt + cnt_w'(1);
            end
        end
    end

    // start bit in bit 0, stop bit shifted in behind the data.
    always_ff @(posedge clk) begin
        if (accept && req_wen) begin
            frame <= {1'b1, req_wdata[7:0], 1'b0};
        end else if (bit_end) begin
            frame <= {1'b1, frame[9:1]};
        end
        if (accept) begin
            resp_rdata <= {{(xlen - 1){1'b0}}, busy};
        end
    end

endmodule

//--- mmio_uart_rx.sv
module mmio_uart_rx #(
    parameter int CLKS_PER_BIT = 234
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      uart_rx,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_wen,
    output logic                      resp_valid,
    output logic [mmio_pkg::xlen-1:0] resp_rdata
);
    import mmio_pkg::*;

    localparam int cnt_w = $clog2(CLKS_PER_BIT + 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic [1:0]       sync;
    logic             line;
    logic [1:0]       state;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_cnt;
    logic [7:0]       shift;
    logic [7:0]       hold;
    logic             full;
    logic             accept;
    logic             half_bit;
    logic             full_bit;

    assign req_ready = 1'b1;
    assign accept    = req_valid && req_ready;
    assign line      = sync[1];
    assign half_bit  = baud_cnt == cnt_w'(CLKS_PER_BIT / 2 - 1);
    assign full_bit  = baud_cnt == cnt_w'(CLKS_PER_BIT - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            sync       <= 2'b11;
            state      <= st_idle;
            baud_cnt   <= '0;
            bit_cnt    <= '0;
            full       <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            sync       <= {sync[0], uart_rx};
            resp_valid <= accept;
            baud_cnt   <= baud_cnt + cnt_w'(1);
            // a read empties the holding register.
            if (accept && !req_wen) begin
                full <= 1'b0;
            end
            case (state)
                st_idle: begin
                    baud_cnt <= '0;
                    if (!line) begin
                        state <= st_start;
                    end
                end
                st_start: if (half_bit) begin
                    // now in the middle of the start bit; a glitch returns to idle.
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= line ? st_idle : st_data;
                end
                st_data: if (full_bit) begin
                    baud_cnt <= '0;
                    bit_cnt  <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state <= st_stop;
                    end
                end
                default: if (full_bit) begin
                    state <= st_idle;
                    if (line) begin
                        full <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && full_bit) begin
            shift <= {line, shift[7:1]};
        end
        if (state == st_stop && full_bit && line) begin
            hold <= shift;
        end
        if (accept) begin
            resp_rdata <= {{(xlen - 9){1'b0}}, full, hold};
        end
    end

endmodule

//--- mmio_clint.sv
module mmio_clint (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic [3:0]                req_addr,
    input  logic                      req_wen,
    input  logic [mmio_pkg::xlen-1:0] req_wdata,
    output logic                      resp_valid,
    output logic [mmio_pkg::xlen-1:0] resp_rdata,
    output logic                      timer_irq
);
    import mmio_pkg::*;

    logic [63:0]     mtime;
    logic [63:0]     mtimecmp;
    logic            accept;
    logic [xlen-1:0] rd_word;

    assign req_ready = 1'b1;
    assign accept    = req_valid && req_ready;

    always_comb begin
        case (req_addr)
            4'h0:    rd_word = mtime[31:0];
            4'h4:    rd_word = mtime[63:32];
            4'h8:    rd_word = mtimecmp[31:0];
            4'hc:    rd_word = mtimecmp[63:32];
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime      <= '0;
            mtimecmp   <= '1;
            timer_irq  <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            mtime      <= mtime + 64'd1;
            timer_irq  <= mtime >= mtimecmp;
            resp_valid <= accept;
            if (accept && req_wen && req_addr == 4'h8) begin
                mtimecmp[31:0] <= req_wdata;
            end
            if (accept && req_wen && req_addr == 4'hc) begin
                mtimecmp[63:32] <= req_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_rdata <= rd_word;
        end
    end

endmodule

//--- mmio_router.sv
module mmio_router #(
    parameter int CLKS_PER_BIT = 234
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          dreq_valid,
    output logic                          dreq_ready,
    input  logic [mmio_pkg::xlen-1:0]     dreq_addr,
    input  logic                          dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]     dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]   dreq_wmask,

    output logic                          dresp_valid,
    output logic [mmio_pkg::xlen-1:0]     dresp_rdata,
    output logic                          dresp_error,
    output mmio_pkg::mmio_errty_e         dresp_errty,

    output logic                          mem_req_valid,
    input  logic                          mem_req_ready,
    output logic [mmio_pkg::xlen-1:0]     mem_req_addr,
    output logic                          mem_req_wen,
    output logic [mmio_pkg::xlen-1:0]     mem_req_wdata,
    output logic [mmio_pkg::xlen/8-1:0]   mem_req_wmask,
    input  logic                          mem_resp_valid,
    input  logic [mmio_pkg::xlen-1:0]     mem_resp_rdata,
    input  logic                          mem_resp_error,

    input  logic                          uart_rx,
    output logic                          uart_tx,
    output logic                          timer_irq
);
    import mmio_pkg::*;

    localparam logic [1:0] st_idle       = 2'd0;
    localparam logic [1:0] st_wait_ready = 2'd1;
    localparam logic [1:0] st_wait_valid = 2'd2;

    function automatic logic in_clint(input logic [xlen-1:0] addr);
        return addr >= clint_base && addr <= clint_end;
    endfunction

    logic [1:0]        state;
    logic [xlen-1:0]   s_addr;
    logic              s_wen;
    logic [xlen-1:0]   s_wdata;
    logic [xlen/8-1:0] s_wmask;

    logic l_tx, l_rx, l_clint;
    logic s_tx, s_rx, s_clint, s_mem;
    logic sel_tx, sel_rx, sel_clint, sel_mem;
    logic take, issue, sel_ready, resp_hit;

    logic [xlen-1:0]   cur_addr;
    logic              cur_wen;
    logic [xlen-1:0]   cur_wdata;

    logic              tx_ready, tx_resp_valid;
    logic [xlen-1:0]   tx_resp_rdata;
    logic              rx_ready, rx_resp_valid;
    logic [xlen-1:0]   rx_resp_rdata;
    logic              clint_ready, clint_resp_valid;
    logic [xlen-1:0]   clint_resp_rdata;

    assign l_tx    = dreq_addr == uart_tx_addr;
    assign l_rx    = dreq_addr == uart_rx_addr;
    assign l_clint = in_clint(dreq_addr);

    assign s_tx    = s_addr == uart_tx_addr;
    assign s_rx    = s_addr == uart_rx_addr;
    assign s_clint = in_clint(s_addr);
    assign s_mem   = !(s_tx || s_rx || s_clint);

    // the outstanding request completes this cycle.
    assign resp_hit = state == st_wait_valid && (
                        (s_tx    && tx_resp_valid)    ||
                        (s_rx    && rx_resp_valid)    ||
                        (s_clint && clint_resp_valid) ||
                        (s_mem   && mem_resp_valid));

    assign dreq_ready = state == st_idle || resp_hit;

    // while the core channel is open the live request goes straight to the target.
    assign take      = dreq_ready;
    assign sel_tx    = take ? l_tx : s_tx;
    assign sel_rx    = take ? l_rx : s_rx;
    assign sel_clint = take ? l_clint : s_clint;
    assign sel_mem   = !(sel_tx || sel_rx || sel_clint);

    assign cur_addr  = take ? dreq_addr : s_addr;
    assign cur_wen   = take ? dreq_wen : s_wen;
    assign cur_wdata = take ? dreq_wdata : s_wdata;
    assign issue     = take ? dreq_valid : state == st_wait_ready;

    assign sel_ready = sel_tx    ? tx_ready :
                       sel_rx    ? rx_ready :
                       sel_clint ? clint_ready :
                                   mem_req_ready;

    assign mem_req_valid = issue && sel_mem;
    assign mem_req_addr  = cur_addr;
    assign mem_req_wen   = cur_wen;
    assign mem_req_wdata = cur_wdata;
    assign mem_req_wmask = take ? dreq_wmask : s_wmask;

    assign dresp_valid = resp_hit;
    assign dresp_rdata = s_tx    ? tx_resp_rdata :
                         s_rx    ? rx_resp_rdata :
                         s_clint ? clint_resp_rdata :
                                   mem_resp_rdata;
    // only the memory can fault.
    assign dresp_error = s_mem && mem_resp_error;
    assign dresp_errty = dresp_error ? errty_access_fault : errty_none;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else if (dreq_ready) begin
            if (dreq_valid) begin
                state <= sel_ready ? st_wait_valid : st_wait_ready;
            end else begin
                state <= st_idle;
            end
        end else if (state == st_wait_ready && sel_ready) begin
            state <= st_wait_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dreq_valid && dreq_ready) begin
            s_addr  <= dreq_addr;
            s_wen   <= dreq_wen;
            s_wdata <= dreq_wdata;
            s_wmask <= dreq_wmask;
        end
    end

    mmio_uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_tx (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (issue && sel_tx),
        .req_ready  (tx_ready),
        .req_wen    (cur_wen),
        .req_wdata  (cur_wdata),
        .resp_valid (tx_resp_valid),
        .resp_rdata (tx_resp_rdata),
        .uart_tx    (uart_tx)
    );

    mmio_uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_uart_rx (
        .clk        (clk),
        .reset      (reset),
        .uart_rx    (uart_rx),
        .req_valid  (issue && sel_rx),
        .req_ready  (rx_ready),
        .req_wen    (cur_wen),
        .resp_valid (rx_resp_valid),
        .resp_rdata (rx_resp_rdata)
    );

    mmio_clint i_clint (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (issue && sel_clint),
        .req_ready  (clint_ready),
        .req_addr   (cur_addr[3:0]),
        .req_wen    (cur_wen),
        .req_wdata  (cur_wdata),
        .resp_valid (clint_resp_valid),
        .resp_rdata (clint_resp_rdata),
        .timer_irq  (timer_irq)
    );

endmodule

//--- data_ram.sv
module data_ram #(
    parameter int RAM_WORDS = 4096
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic [mmio_pkg::xlen-1:0]   req_addr,
    input  logic                        req_wen,
    input  logic [mmio_pkg::xlen-1:0]   req_wdata,
    input  logic [mmio_pkg::xlen/8-1:0] req_wmask,
    output logic                        resp_valid,
    output logic [mmio_pkg::xlen-1:0]   resp_rdata,
    output logic                        resp_error
);
    import mmio_pkg::*;

    localparam int idx_w = $clog2(RAM_WORDS);

    logic [xlen-1:0]   mem [RAM_WORDS];
    logic [xlen-3:0]   word;
    logic [idx_w-1:0]  idx;
    logic              in_range;
    logic              accept;

    assign req_ready = 1'b1;
    assign accept    = req_valid && req_ready;
    assign word      = req_addr[xlen-1:2];
    assign idx       = word[idx_w-1:0];
    assign in_range  = word < (xlen - 2)'(RAM_WORDS);

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_rdata <= in_range ? mem[idx] : '0;
            resp_error <= !in_range;
            if (req_wen && in_range) begin
                for (int i = 0; i < xlen / 8; i++) begin
                    if (req_wmask[i]) begin
                        mem[idx][i*8 +: 8] <= req_wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- mmio_subsystem.sv
module mmio_subsystem #(
    parameter int CLKS_PER_BIT = 234,
    parameter int RAM_WORDS    = 4096
) (
    input  logic                        clk,
    input  logic                        reset,

    input  logic                        dreq_valid,
    output logic                        dreq_ready,
    input  logic [mmio_pkg::xlen-1:0]   dreq_addr,
    input  logic                        dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]   dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0] dreq_wmask,

    output logic                        dresp_valid,
    output logic [mmio_pkg::xlen-1:0]   dresp_rdata,
    output logic                        dresp_error,
    output mmio_pkg::mmio_errty_e       dresp_errty,

    input  logic                        uart_rx,
    output logic                        uart_tx,
    output logic                        timer_irq
);
    import mmio_pkg::*;

    logic              mem_req_valid;
    logic              mem_req_ready;
    logic [xlen-1:0]   mem_req_addr;
    logic              mem_req_wen;
    logic [xlen-1:0]   mem_req_wdata;
    logic [xlen/8-1:0] mem_req_wmask;
    logic              mem_resp_valid;
    logic [xlen-1:0]   mem_resp_rdata;
    logic              mem_resp_error;

    mmio_router #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_router (
        .clk            (clk),
        .reset          (reset),
        .dreq_valid     (dreq_valid),
        .dreq_ready     (dreq_ready),
        .dreq_addr      (dreq_addr),
        .dreq_wen       (dreq_wen),
        .dreq_wdata     (dreq_wdata),
        .dreq_wmask     (dreq_wmask),
        .dresp_valid    (dresp_valid),
        .dresp_rdata    (dresp_rdata),
        .dresp_error    (dresp_error),
        .dresp_errty    (dresp_errty),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_req_wen    (mem_req_wen),
        .mem_req_wdata  (mem_req_wdata),
        .mem_req_wmask  (mem_req_wmask),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .mem_resp_error (mem_resp_error),
        .uart_rx        (uart_rx),
        .uart_tx        (uart_tx),
        .timer_irq      (timer_irq)
    );

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) i_ram (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (mem_req_valid),
        .req_ready  (mem_req_ready),
        .req_addr   (mem_req_addr),
        .req_wen    (mem_req_wen),
        .req_wdata  (mem_req_wdata),
        .req_wmask  (mem_req_wmask),
        .resp_valid (mem_resp_valid),
        .resp_rdata (mem_resp_rdata),
        .resp_error (mem_resp_error)
    );

endmodule

//--- mmio_router_properties.sv
module mmio_router_properties (
    input logic       clk,
    input logic       reset,
    input logic       dreq_valid,
    input logic       dreq_ready,
    input logic       dresp_valid,
    input logic [1:0] state,
    input logic       sel_ready,
    input logic       s_tx,
    input logic       tx_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] wait_ready_st = 2'd1;

    int   prop_errors = 0;
    logic reset_q;
    logic pending;
    logic fast;
    logic tx_release;

    // pending marks an accepted request whose response has not left yet.
    always_ff @(posedge clk) begin
        reset_q <= reset;
        if (reset) begin
            pending    <= 1'b0;
            fast       <= 1'b0;
            tx_release <= 1'b0;
        end else begin
            if (dreq_valid && dreq_ready) begin
                pending <= 1'b1;
            end else if (dresp_valid) begin
                pending <= 1'b0;
            end
            fast       <= dreq_valid && dreq_ready && sel_ready;
            tx_release <= state == wait_ready_st && s_tx && tx_ready;
        end
    end

    a_reset_idle: assert property (@(posedge clk) reset_q |-> dreq_ready && !dresp_valid)
        else begin
            prop_errors++;
            $error("core channel is not idle after reset");
        end

    a_no_orphan: assert property (@(posedge clk) disable iff (reset)
        dresp_valid |-> pending)
        else begin
            prop_errors++;
            $error("response without an accepted request");
        end

    a_one_per_accept: assert property (@(posedge clk) disable iff (reset)
        dreq_valid && dreq_ready && pending |-> dresp_valid)
        else begin
            prop_errors++;
            $error("new request accepted before the previous response");
        end

    a_ready_latency: assert property (@(posedge clk) disable iff (reset)
        fast |-> dresp_valid)
        else begin
            prop_errors++;
            $error("response late although the target was ready");
        end

    a_tx_hold: assert property (@(posedge clk) disable iff (reset)
        tx_release |-> dresp_valid)
        else begin
            prop_errors++;
            $error("held transmit request not answered when the frame ended");
        end

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset covers eight rising edges and is released on a falling edge.
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb_mmio_subsystem.sv
module tb_mmio_subsystem;
    timeunit 1ns;
    timeprecision 100ps;
    import mmio_pkg::*;

    localparam int clks_per_bit = 8;
    localparam int ram_words    = 256;
    // about 40 requests and three serial frames, with a wide margin.
    localparam int timeout_cycles = 40 * 25 + 3 * 10 * clks_per_bit * 4;

    logic        clk;
    logic        reset;
    logic        dreq_valid;
    logic        dreq_ready;
    logic [31:0] dreq_addr;
    logic        dreq_wen;
    logic [31:0] dreq_wdata;
    logic [3:0]  dreq_wmask;
    logic        dresp_valid;
    logic [31:0] dresp_rdata;
    logic        dresp_error;
    mmio_errty_e dresp_errty;
    logic        serial_line;
    logic        timer_irq;

    logic [31:0] seed = 32'hf192;
    logic [31:0] mirror [ram_words];
    logic [7:0]  sent_bytes [$];
    logic [31:0] resp_data;
    logic        resp_err;
    mmio_errty_e resp_errty;
    int          resp_latency;
    int          frames_done = 0;
    int          errors = 0;
    int          timeouts = 0;
    int          cycles = 0;

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    mmio_subsystem #(
        .CLKS_PER_BIT (clks_per_bit),
        .RAM_WORDS    (ram_words)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dreq_addr   (dreq_addr),
        .dreq_wen    (dreq_wen),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dresp_valid (dresp_valid),
        .dresp_rdata (dresp_rdata),
        .dresp_error (dresp_error),
        .dresp_errty (dresp_errty),
        .uart_rx     (serial_line),
        .uart_tx     (serial_line),
        .timer_irq   (timer_irq)
    );

    bind mmio_router mmio_router_properties i_props (
        .clk         (clk),
        .reset       (reset),
        .dreq_valid  (dreq_valid),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .state       (state),
        .sel_ready   (sel_ready),
        .s_tx        (s_tx),
        .tx_ready    (tx_ready)
    );

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                word[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return word;
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            errors++;
            $display("FAILED %0t: %s", $time, what);
        end
    endtask

    // one request from a falling edge until its response, sampled on falling edges.
    task automatic issue_request(input logic [31:0] addr, input logic wen,
                                 input logic [31:0] wdata, input logic [3:0] wmask);
        @(negedge clk);
        dreq_valid = 1'b1;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        dreq_wmask = wmask;
        while (!dreq_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        dreq_valid   = 1'b0;
        resp_latency = 1;
        while (!dresp_valid) begin
            @(negedge clk);
            resp_latency++;
        end
        resp_data  = dresp_rdata;
        resp_err   = dresp_error;
        resp_errty = dresp_errty;
    endtask

    task automatic periph_access(input logic [31:0] addr, input logic wen,
                                 input logic [31:0] wdata);
        issue_request(addr, wen, wdata, 4'hf);
        expect_true(!resp_err, "peripheral response flagged an error");
    endtask

    task automatic ram_store(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        issue_request(addr, 1'b1, data, mask);
        expect_true(!resp_err, "RAM write inside the array flagged an error");
        mirror[addr[2 +: 8]] = merge_bytes(mirror[addr[2 +: 8]], data, mask);
    endtask

    task automatic ram_check(input logic [31:0] addr);
        issue_request(addr, 1'b0, 32'd0, 4'h0);
        expect_true(!resp_err, "RAM read inside the array flagged an error");
        expect_equal("RAM word", resp_data, mirror[addr[2 +: 8]]);
    endtask

    task automatic expect_fault(input logic [31:0] addr, input logic wen);
        issue_request(addr, wen, 32'hdead_beef, 4'hf);
        expect_true(resp_err, "access beyond the RAM returned no error");
        expect_equal("error type", 32'(resp_errty), 32'(errty_access_fault));
    endtask

    task automatic send_byte(input logic [7:0] b);
        sent_bytes.push_back(b);
        periph_access(uart_tx_addr, 1'b1, {24'd0, b});
    endtask

    task automatic wait_frames(input int n);
        while (frames_done < n) begin
            @(negedge clk);
        end
    endtask

    // reads the receiver until it reports a byte, then once more to see the flag clear.
    task automatic receive_check(input logic [7:0] b);
        periph_access(uart_rx_addr, 1'b0, 32'd0);
        while (!resp_data[8]) begin
            periph_access(uart_rx_addr, 1'b0, 32'd0);
        end
        expect_equal("received byte", {24'd0, resp_data[7:0]}, {24'd0, b});
        periph_access(uart_rx_addr, 1'b0, 32'd0);
        expect_true(!resp_data[8], "receive flag still set after a read");
    endtask

    task automatic finish_run();
        int total;
        total = errors + i_dut.i_router.i_props.prop_errors + timeouts;
        $display("value errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, i_dut.i_router.i_props.prop_errors, timeouts);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    // serial monitor on the looped-back line, sampling each bit in its middle.
    initial begin
        logic [7:0] rx_byte;
        logic [7:0] exp_byte;
        forever begin
            @(negedge clk);
            if (!reset && serial_line == 1'b0) begin
                repeat (clks_per_bit / 2) @(negedge clk);
                expect_true(serial_line == 1'b0, "start bit is not low in its middle");
                for (int i = 0; i < 8; i++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    rx_byte[i] = serial_line;
                end
                repeat (clks_per_bit) @(negedge clk);
                expect_true(serial_line == 1'b1, "stop bit is not high");
                exp_byte = sent_bytes.size() > 0 ? sent_bytes.pop_front() : 8'h00;
                expect_equal("serial byte", {24'd0, rx_byte}, {24'd0, exp_byte});
                repeat (clks_per_bit / 2) @(negedge clk);
                frames_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == timeout_cycles) begin
            timeouts = 1;
            $display("timeout: the tests did not end within %0d clock cycles", timeout_cycles);
            finish_run();
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] t0;
        logic [31:0] t1;
        dreq_valid = 1'b0;
        dreq_addr  = 32'd0;
        dreq_wen   = 1'b0;
        dreq_wdata = 32'd0;
        dreq_wmask = 4'h0;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        expect_true(dreq_ready && !dresp_valid, "core channel not idle after reset");

        for (int n = 0; n < 6; n++) begin
            data = lcg_next();
            addr = {22'd0, data[7:0], 2'b00};
            ram_store(addr, lcg_next(), 4'hf);
            data = lcg_next();
            ram_store(addr, lcg_next(), data[3:0]);
            ram_check(addr);
        end

        // word 256 would alias word 0 if the range check failed.
        ram_store(32'h0000_0000, lcg_next(), 4'hf);
        expect_fault(32'h0000_0400, 1'b0);
        expect_fault(32'h0001_0000, 1'b0);
        expect_fault(32'h0000_0400, 1'b1);
        ram_check(32'h0000_0000);

        data = lcg_next();
        send_byte(data[7:0]);
        wait_frames(1);
        receive_check(data[7:0]);

        data = lcg_next();
        send_byte(data[7:0]);
        send_byte(data[15:8]);
        expect_true(frames_done >= 2, "second transmit write finished inside a frame");
        expect_true(resp_latency > clks_per_bit, "second transmit write was not held");
        // a status read also waits for the frame, so it sees the transmitter idle.
        periph_access(uart_tx_addr, 1'b0, 32'd0);
        expect_true(frames_done >= 3, "transmit read finished inside a frame");
        expect_equal("transmit busy flag", resp_data, 32'd0);
        wait_frames(3);
        receive_check(data[15:8]);

        periph_access(clint_base + 32'hc, 1'b1, 32'd0);
        periph_access(clint_base, 1'b0, 32'd0);
        t0 = resp_data;
        periph_access(clint_base, 1'b0, 32'd0);
        t1 = resp_data;
        expect_true(t1 > t0, "mtime did not advance between reads");
        periph_access(clint_base + 32'h4, 1'b0, 32'd0);
        expect_equal("mtime high", resp_data, 32'd0);
        periph_access(clint_base + 32'h8, 1'b1, t1 + 32'd40);
        expect_true(!timer_irq, "timer interrupt raised before mtimecmp was reached");
        while (!timer_irq) begin
            @(negedge clk);
        end
        periph_access(clint_base, 1'b0, 32'd0);
        expect_true(resp_data >= t1 + 32'd40, "timer interrupt raised below mtimecmp");

        finish_run();
    end

endmodule

//--- mmio_subsystem.f
mmio_pkg.sv
mmio_uart_tx.sv
mmio_uart_rx.sv
mmio_clint.sv
mmio_router.sv
data_ram.sv
mmio_subsystem.sv
mmio_router_properties.sv
tb_clock.sv
tb_mmio_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mmio_subsystem -f mmio_subsystem.f -o tb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
